// ==== source/fec_pkg.sv ====
`default_nettype none

package fec_pkg;

    // symbol and stream word sizes.
    localparam int SYM_SIZE     = 8;
    localparam int DATA_WID     = 64;
    localparam int SYM_PER_WORD = DATA_WID / SYM_SIZE;

    // block shape, columns by symbols per column.
    localparam int FEC_NUM_COL  = 4;
    localparam int SYM_PER_COL  = 16;
    localparam int CLKS_PER_COL = SYM_PER_COL / SYM_PER_WORD;  // words per column.
    localparam int CLKS_PER_BLK = CLKS_PER_COL * FEC_NUM_COL;  // words per block.

    // column buffering.
    localparam int NUM_BUFS     = 2;  // one buffer filling, one draining.
    localparam int COL_ADDR_WID = $clog2(CLKS_PER_COL);

    // output FIFO.
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_MARGIN  = 3;  // slots held back for reads still in the pipeline.

    typedef logic [SYM_SIZE-1:0] sym_t;

    // symbol k sits at bits k*SYM_SIZE upward.
    typedef sym_t [SYM_PER_WORD-1:0] fec_word_t;

    typedef logic [$clog2(CLKS_PER_BLK)-1:0] word_idx_t;  // word index within a block.
    typedef logic [COL_ADDR_WID-1:0] col_addr_t;

    // transposer direction.
    typedef enum logic {
        CW_TO_COL,  // codeword order in, column order out.
        COL_TO_CW   // column order in, codeword order out.
    } fec_blk_transpose_mode_t;

    typedef enum logic {
        RD_IDLE,
        RD_STREAM
    } rd_state_t;

    // write request into one column.
    typedef struct packed {
        logic      req;
        col_addr_t addr;
        fec_word_t data;
    } col_wr_t;

    // read request, shared by all columns.
    typedef struct packed {
        logic      req;
        col_addr_t addr;
    } col_rd_t;

endpackage

`default_nettype wire

// ==== source/fec_col_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module fec_col_buf (
    input  logic              clk,
    input  logic              srst,

    input  logic              buf_sel,  // buffer on the write side.

    input  fec_pkg::col_wr_t  wr,
    input  fec_pkg::col_rd_t  rd,
    output fec_pkg::fec_word_t rd_data
);

    // storage, one RAM per buffer.
    fec_pkg::fec_word_t ram [fec_pkg::NUM_BUFS][fec_pkg::CLKS_PER_COL];

    logic               rd_buf;  // buffer on the read side.
    fec_pkg::fec_word_t ram_q;   // registered RAM output.

    // reads always come from the buffer that is not being filled.
    assign rd_buf = ~buf_sel;

    // write port.
    always_ff @(posedge clk) begin
        if (wr.req) begin
            ram[buf_sel][wr.addr] <= wr.data;
        end
    end

    // read port, first register stage.
    always_ff @(posedge clk) begin
        if (rd.req) begin
            ram_q <= ram[rd_buf][rd.addr];
        end
    end

    // second register stage, the column's output.
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_data <= '0;
        end else begin
            rd_data <= ram_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/fec_sym_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module fec_sym_fifo (
    input  logic               clk,
    input  logic               srst,

    input  logic               wr,
    input  fec_pkg::fec_word_t wr_data,
    output logic               wr_rdy,

    input  logic               rd,
    output fec_pkg::fec_word_t rd_data,
    output logic               empty
);

    logic [fec_pkg::DATA_WID-1:0] mem [fec_pkg::FIFO_DEPTH];

    logic [$clog2(fec_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(fec_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(fec_pkg::FIFO_DEPTH+1)-1:0] count;  // words held.

    logic full;
    logic push;
    logic pop;

    assign full  = (count == fec_pkg::FIFO_DEPTH);
    assign empty = (count == 0);

    // a write into a full FIFO is dropped.
    assign push = wr && !full;
    assign pop  = rd && !empty;

    // ready only while enough room is left for reads in flight.
    assign wr_rdy = (count <= (fec_pkg::FIFO_DEPTH - fec_pkg::FIFO_MARGIN));

    // head word, no read latency.
    assign rd_data = fec_pkg::fec_word_t'(mem[rd_ptr]);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fec_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fec_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/fec_blk_transpose.sv ====
`timescale 1ns/100ps
`default_nettype none

module fec_blk_transpose #(
    parameter fec_pkg::fec_blk_transpose_mode_t MODE = fec_pkg::CW_TO_COL
) (
    input  logic               clk,
    input  logic               srst,

    input  fec_pkg::fec_word_t data_in,
    input  logic               data_in_valid,
    output logic               data_in_ready,

    output fec_pkg::fec_word_t data_out,
    output logic               data_out_valid,
    input  logic               data_out_ready
);

    // input side.
    logic               in_fire;   // word accepted this cycle.
    fec_pkg::word_idx_t wr_idx;    // index of the next incoming word.
    logic               buf_sel;   // buffer being filled.
    fec_pkg::col_addr_t wr_addr;

    fec_pkg::col_wr_t   col_wr [fec_pkg::FEC_NUM_COL];

    // read side.
    fec_pkg::rd_state_t rd_state;
    fec_pkg::word_idx_t rd_idx;    // index of the next output word.
    logic               sel_q;     // buf_sel one cycle late, for swap detection.
    logic               rd_fire;
    fec_pkg::col_addr_t rd_addr;

    fec_pkg::col_rd_t   col_rd;
    fec_pkg::fec_word_t col_rd_data [fec_pkg::FEC_NUM_COL];

    // read pipeline, aligned with the two RAM register stages.
    logic [1:0]               pipe_req;
    fec_pkg::word_idx_t [1:0] pipe_idx;

    // output FIFO.
    fec_pkg::fec_word_t fifo_in;
    logic               fifo_wr_rdy;
    logic               fifo_rd;
    logic               fifo_empty;

    // input stalls together with the output.
    assign data_in_ready = data_out_ready;
    assign in_fire       = data_in_valid && data_in_ready;

    // word counter, the buffers swap once a block is complete.
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_idx  <= '0;
            buf_sel <= 1'b0;
        end else if (in_fire) begin
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == fec_pkg::word_idx_t'(fec_pkg::CLKS_PER_BLK - 1)) begin
                buf_sel <= ~buf_sel;
            end
        end
    end

    // address mapping for each direction.
    if (MODE == fec_pkg::CW_TO_COL) begin : g_addr_cw
        assign wr_addr = fec_pkg::col_addr_t'(wr_idx / fec_pkg::FEC_NUM_COL);
        assign rd_addr = fec_pkg::col_addr_t'(rd_idx % fec_pkg::CLKS_PER_COL);
    end else begin : g_addr_col
        assign wr_addr = fec_pkg::col_addr_t'(wr_idx % fec_pkg::CLKS_PER_COL);
        assign rd_addr = fec_pkg::col_addr_t'(rd_idx / fec_pkg::FEC_NUM_COL);
    end

    // read burst control.
    assign rd_fire = (rd_state == fec_pkg::RD_STREAM) && data_out_ready && fifo_wr_rdy;
    assign col_rd  = '{req: rd_fire, addr: rd_addr};

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_state <= fec_pkg::RD_IDLE;
            rd_idx   <= '0;
            sel_q    <= 1'b0;
        end else begin
            sel_q <= buf_sel;
            case (rd_state)
                fec_pkg::RD_IDLE: begin
                    if (buf_sel != sel_q) begin  // a block just finished filling.
                        rd_state <= fec_pkg::RD_STREAM;
                        rd_idx   <= '0;
                    end
                end
                fec_pkg::RD_STREAM: begin
                    if (rd_fire) begin
                        rd_idx <= rd_idx + 1'b1;
                        if (rd_idx == fec_pkg::word_idx_t'(fec_pkg::CLKS_PER_BLK - 1)) begin
                            rd_state <= fec_pkg::RD_IDLE;
                        end
                    end
                end
                default: rd_state <= fec_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            pipe_req <= '0;
        end else begin
            pipe_req <= {pipe_req[0], rd_fire};
        end
    end

    always_ff @(posedge clk) begin
        pipe_idx[0] <= rd_idx;
        pipe_idx[1] <= pipe_idx[0];
    end

    // column buffers.
    for (genvar i = 0; i < fec_pkg::FEC_NUM_COL; i++) begin : g_col
        logic wr_hit;  // incoming word belongs to this column.

        if (MODE == fec_pkg::CW_TO_COL) begin : g_hit_cw
            assign wr_hit = ((wr_idx % fec_pkg::FEC_NUM_COL) == i);
        end else begin : g_hit_col
            assign wr_hit = ((wr_idx / fec_pkg::CLKS_PER_COL) == i);
        end

        assign col_wr[i] = '{req: in_fire && wr_hit, addr: wr_addr, data: data_in};

        fec_col_buf u_col_buf (
            .clk     (clk),
            .srst    (srst),
            .buf_sel (buf_sel),
            .wr      (col_wr[i]),
            .rd      (col_rd),
            .rd_data (col_rd_data[i])
        );
    end

    // gather symbols from all columns into one output word.
    always_comb begin
        fifo_in = '0;
        for (int i = 0; i < fec_pkg::FEC_NUM_COL; i++) begin
            for (int j = 0; j < fec_pkg::SYM_PER_WORD / fec_pkg::FEC_NUM_COL; j++) begin
                if (MODE == fec_pkg::CW_TO_COL) begin
                    fifo_in[i * (fec_pkg::SYM_PER_WORD / fec_pkg::FEC_NUM_COL) + j] =
                        col_rd_data[i][pipe_idx[1] / fec_pkg::CLKS_PER_COL
                                       + j * fec_pkg::FEC_NUM_COL];
                end else begin
                    fifo_in[j * fec_pkg::FEC_NUM_COL + i] =
                        col_rd_data[i][(pipe_idx[1] % fec_pkg::FEC_NUM_COL)
                                       * (fec_pkg::SYM_PER_WORD / fec_pkg::FEC_NUM_COL) + j];
                end
            end
        end
    end

    // output valid only on a pop, so a word is never held against ready low.
    assign fifo_rd        = data_out_ready && !fifo_empty;
    assign data_out_valid = fifo_rd;

    fec_sym_fifo u_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (pipe_req[1]),
        .wr_data (fifo_in),
        .wr_rdy  (fifo_wr_rdy),
        .rd      (fifo_rd),
        .rd_data (data_out),
        .empty   (fifo_empty)
    );

endmodule

`default_nettype wire

// ==== source/fec_interleave_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fec_interleave_top (
    input  logic               clk,
    input  logic               srst,

    // transmit side, codeword order in and column order out.
    input  fec_pkg::fec_word_t tx_in,
    input  logic               tx_in_valid,
    output logic               tx_in_ready,
    output fec_pkg::fec_word_t tx_out,
    output logic               tx_out_valid,
    input  logic               tx_out_ready,

    // receive side, column order in and codeword order out.
    input  fec_pkg::fec_word_t rx_in,
    input  logic               rx_in_valid,
    output logic               rx_in_ready,
    output fec_pkg::fec_word_t rx_out,
    output logic               rx_out_valid,
    input  logic               rx_out_ready
);

    fec_blk_transpose #(.MODE(fec_pkg::CW_TO_COL)) u_tx (
        .clk            (clk),
        .srst           (srst),
        .data_in        (tx_in),
        .data_in_valid  (tx_in_valid),
        .data_in_ready  (tx_in_ready),
        .data_out       (tx_out),
        .data_out_valid (tx_out_valid),
        .data_out_ready (tx_out_ready)
    );

    fec_blk_transpose #(.MODE(fec_pkg::COL_TO_CW)) u_rx (
        .clk            (clk),
        .srst           (srst),
        .data_in        (rx_in),
        .data_in_valid  (rx_in_valid),
        .data_in_ready  (rx_in_ready),
        .data_out       (rx_out),
        .data_out_valid (rx_out_valid),
        .data_out_ready (rx_out_ready)
    );

endmodule

`default_nettype wire

// ==== tb/tb_fec_interleave.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fec_interleave;

    localparam int WORDS       = fec_pkg::CLKS_PER_BLK;  // words per block.
    localparam int BASE_BLOCKS = 6;                      // blocks with ready always high.
    localparam int BP_BLOCKS   = 4;                      // blocks with random back-pressure.
    localparam int TOTAL_WORDS = (BASE_BLOCKS + BP_BLOCKS) * WORDS;
    localparam int WATCHDOG_NS = 20 * TOTAL_WORDS * 20 + 2000;

    logic               clk;
    logic               srst;
    fec_pkg::fec_word_t tx_in;
    logic               tx_in_valid;
    logic               tx_in_ready;
    fec_pkg::fec_word_t tx_out;
    logic               tx_out_valid;
    logic               tx_out_ready;
    fec_pkg::fec_word_t rx_in;
    logic               rx_in_valid;
    logic               rx_in_ready;
    fec_pkg::fec_word_t rx_out;
    logic               rx_out_valid;
    logic               rx_out_ready;

    fec_pkg::fec_word_t tx_exp [$];   // column-order words due on tx_out.
    fec_pkg::fec_word_t rx_exp [$];   // original words due on rx_out.
    fec_pkg::fec_word_t chan_q [$];   // external channel from tx_out to rx_in.
    fec_pkg::fec_word_t blk_words [WORDS];
    fec_pkg::fec_word_t exp_word;

    int    errors       = 0;
    int    checks       = 0;
    int    tx_out_count = 0;
    int    rx_out_count = 0;
    int    cycle        = 0;
    logic  srst_q       = 1'b1;
    logic  bp_en        = 1'b0;  // random back-pressure on the output sides.

    fec_interleave_top DUT (
        .clk          (clk),
        .srst         (srst),
        .tx_in        (tx_in),
        .tx_in_valid  (tx_in_valid),
        .tx_in_ready  (tx_in_ready),
        .tx_out       (tx_out),
        .tx_out_valid (tx_out_valid),
        .tx_out_ready (tx_out_ready),
        .rx_in        (rx_in),
        .rx_in_valid  (rx_in_valid),
        .rx_in_ready  (rx_in_ready),
        .rx_out       (rx_out),
        .rx_out_valid (rx_out_valid),
        .rx_out_ready (rx_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic count_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // reference model, symbol s of the block goes to position p = c*SYM_PER_COL + r.
    task automatic queue_expected();
        fec_pkg::fec_word_t out_word;
        int p;
        int s;
        for (int o = 0; o < WORDS; o++) begin
            for (int k = 0; k < fec_pkg::SYM_PER_WORD; k++) begin
                p = o * fec_pkg::SYM_PER_WORD + k;
                s = (p % fec_pkg::SYM_PER_COL) * fec_pkg::FEC_NUM_COL + p / fec_pkg::SYM_PER_COL;
                out_word[k] = blk_words[s / fec_pkg::SYM_PER_WORD][s % fec_pkg::SYM_PER_WORD];
            end
            tx_exp.push_back(out_word);
            rx_exp.push_back(blk_words[o]);
        end
    endtask

    task automatic send_block(input int blk);
        logic accepted;
        for (int w = 0; w < WORDS; w++) begin
            blk_words[w] = {$urandom, $urandom};
        end
        queue_expected();
        for (int w = 0; w < WORDS; w++) begin
            // last word swaps the buffers, the previous block has to be out by then.
            while ((w == WORDS - 1) && (tx_out_count < blk * WORDS)) begin
                @(posedge clk);
                #1;
            end
            tx_in       = blk_words[w];
            tx_in_valid = 1'b1;
            accepted    = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                accepted = tx_in_ready;
                #1;
            end
            tx_in_valid = 1'b0;
        end
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            #1;
            if (bp_en) begin
                tx_out_ready = ($urandom % 4) != 0;
                rx_out_ready = ($urandom % 4) != 0;
            end else begin
                tx_out_ready = 1'b1;
                rx_out_ready = 1'b1;
            end
        end
    endtask

    // rx source, fed from the channel with the same block pacing as tx.
    initial begin : rx_feed
        int   sent;
        logic accepted;
        sent        = 0;
        rx_in       = '0;
        rx_in_valid = 1'b0;
        forever begin
            @(posedge clk);
            accepted = rx_in_valid && rx_in_ready;
            #1;
            if (accepted) begin
                void'(chan_q.pop_front());
                sent++;
            end
            if ((chan_q.size() > 0)
                && ((sent % WORDS != WORDS - 1) || (rx_out_count >= sent - (WORDS - 1)))) begin
                rx_in       = chan_q[0];
                rx_in_valid = 1'b1;
            end else begin
                rx_in_valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle  <= cycle + 1;
        srst_q <= srst;
    end

    // output monitors, both sides sampled on the rising edge.
    always @(posedge clk) begin
        if (!srst && tx_out_valid) begin
            tx_out_count++;
            chan_q.push_back(tx_out);
            if (tx_exp.size() == 0) begin
                report_failure("tx_out produced a word that was never expected");
            end else begin
                exp_word = tx_exp.pop_front();
                checks++;
                assert (tx_out === exp_word)
                    else count_mismatch($sformatf("tx_out is %h, expected %h", tx_out, exp_word));
            end
        end
        if (!srst && rx_out_valid) begin
            rx_out_count++;
            if (rx_exp.size() == 0) begin
                report_failure("rx_out produced a word that was never expected");
            end else begin
                exp_word = rx_exp.pop_front();
                checks++;
                assert (rx_out === exp_word)
                    else count_mismatch($sformatf("rx_out is %h, expected %h", rx_out, exp_word));
            end
        end
    end

    // first edge skipped, the FIFO count is still unknown there.
    assert property (@(posedge clk) ((cycle != 0) && (srst || srst_q))
                     |-> (!tx_out_valid && !rx_out_valid))
        else count_mismatch("output valid high during or right after reset");

    assert property (@(posedge clk) tx_in_ready == tx_out_ready)
        else count_mismatch("tx_in_ready differs from tx_out_ready");
    assert property (@(posedge clk) rx_in_ready == rx_out_ready)
        else count_mismatch("rx_in_ready differs from rx_out_ready");

    assert property (@(posedge clk) disable iff (srst) !tx_out_ready |-> !tx_out_valid)
        else count_mismatch("tx_out_valid high while tx_out_ready is low");
    assert property (@(posedge clk) disable iff (srst) !rx_out_ready |-> !rx_out_valid)
        else count_mismatch("rx_out_valid high while rx_out_ready is low");

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the output streams did not drain within %0d ns", WATCHDOG_NS);
        $display("errors: %0d, checks: %0d", errors + 1, checks);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main
        void'($urandom(11));
        srst         = 1'b1;
        tx_in        = '0;
        tx_in_valid  = 1'b0;
        tx_out_ready = 1'b1;
        rx_out_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        srst = 1'b0;

        fork
            drive_ready();
        join_none

        for (int b = 0; b < BASE_BLOCKS; b++) begin
            send_block(b);
        end
        bp_en = 1'b1;
        for (int b = BASE_BLOCKS; b < BASE_BLOCKS + BP_BLOCKS; b++) begin
            send_block(b);
        end

        // the final block has to come out with no more input.
        while ((tx_exp.size() != 0) || (rx_exp.size() != 0)) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // room for late duplicates.

        checks += 3;
        assert (tx_out_count == TOTAL_WORDS)
            else count_mismatch($sformatf("tx_out gave %0d words, expected %0d",
                                          tx_out_count, TOTAL_WORDS));
        assert (rx_out_count == TOTAL_WORDS)
            else count_mismatch($sformatf("rx_out gave %0d words, expected %0d",
                                          rx_out_count, TOTAL_WORDS));
        assert (chan_q.size() == 0)
            else report_failure("channel still holds words that rx never took");

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fec_interleave.f ====
source/fec_pkg.sv
source/fec_col_buf.sv
source/fec_sym_fifo.sv
source/fec_blk_transpose.sv
source/fec_interleave_top.sv
tb/tb_fec_interleave.sv

// ==== Bender.yml ====
package:
  name: fec_interleave

sources:
  # package first, then the design from the leaves up.
  - source/fec_pkg.sv
  - source/fec_col_buf.sv
  - source/fec_sym_fifo.sv
  - source/fec_blk_transpose.sv
  - source/fec_interleave_top.sv

  # testbench, top module tb_fec_interleave.
  - target: test
    files:
      - tb/tb_fec_interleave.sv
